/* Bender.yml */
package:
  name: lspc

sources:
  - files:
      - rtl/lspcPkg.sv
      - rtl/pixelClockGen.sv
      - rtl/hostRegisters.sv
      - rtl/videoCounter.sv
      - rtl/rasterTimer.sv
      - rtl/vramPort.sv
      - rtl/interruptControl.sv
      - rtl/lspcTop.sv
  - target: test
    files:
      - bench/lspcTb.sv

/* all.f */
rtl/lspcPkg.sv
rtl/pixelClockGen.sv
rtl/hostRegisters.sv
rtl/videoCounter.sv
rtl/rasterTimer.sv
rtl/vramPort.sv
rtl/interruptControl.sv
rtl/lspcTop.sv
bench/lspcTb.sv

/* bench/lspcTb.sv */
`timescale 1ns/1ps

module lspcTb;

	import lspcPkg::*;

	localparam bit VIDEO_MODE = 1'b1;
	localparam int VRAM_AW = 16;
	localparam int ADDR_MASK = (1 << VRAM_AW) - 1;
	localparam int FRAME_LINES = int'(V_LAST) - int'(V_FIRST) + 1;
	// 4 clocks per pixel
	localparam int LINE_CYCLES = H_TOTAL * 4;
	localparam int FRAME_CYCLES = FRAME_LINES * LINE_CYCLES;

	logic CLK_24M;
	logic RESET;
	logic [2:0] hostAddr;
	hostWord_t hostWrData;
	logic hostWrite;
	hostWord_t hostRdData;
	logic vramBusy;
	logic [1:0] irqLevel;
	logic hsync;
	logic vsyncN;
	logic blank;
	logic clk8M;
	logic clk4M;

	// Rising edges since reset release
	int cycleNo;
	// Main sequence state
	int unsigned seedValue;
	hostWord_t vramModWord;
	int vramBase;
	int vramPtr;
	int k;
	hostWord_t rdWord;
	hostWord_t dataWord;
	int wrAddr [8];
	hostWord_t wrWord [8];
	int timerCnt;
	int periodBound;
	logic [2:0] modeBits;
	// Monitor state
	logic last4M;
	int since4M;
	bit seen4M;
	int since8M;
	bit seen8M;
	int vsyncLowCycles;
	logic [8:0] modeVCount;
	logic [8:0] lastModeVCount;
	bit modeSampleValid;

	lspcTop #(
		.VIDEO_MODE(VIDEO_MODE),
		.VRAM_AW(VRAM_AW)
	) dut0 (
		.CLK_24M(CLK_24M),
		.RESET(RESET),
		.hostAddr(hostAddr),
		.hostWrData(hostWrData),
		.hostWrite(hostWrite),
		.hostRdData(hostRdData),
		.vramBusy(vramBusy),
		.irqLevel(irqLevel),
		.hsync(hsync),
		.vsyncN(vsyncN),
		.blank(blank),
		.clk8M(clk8M),
		.clk4M(clk4M)
	);

	initial
	begin
		CLK_24M = 1'b0;
		forever
			#20 CLK_24M = ~CLK_24M;
	end

	always @(posedge CLK_24M or posedge RESET)
	begin
		if (RESET)
			cycleNo <= 0;
		else
			cycleNo <= cycleNo + 1;
	end

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("Test FAILED");
		$fatal(1);
	endtask

	// Raster line after edge n, one pixel per 4 edges
	function automatic logic [8:0] expVCount(input int n);
		int lineNo;
		lineNo = ((n / 4) / H_TOTAL) % FRAME_LINES;
		return V_FIRST + 9'(lineNo);
	endfunction

	// Pixel within the line after edge n
	function automatic int expHCount(input int n);
		return (n / 4) % H_TOTAL;
	endfunction

	// Blanked outside lines 110 to 1EF and right of pixel 319
	function automatic bit expBlank(input int n);
		return (expHCount(n) >= 320) || (expVCount(n) < V_BLANK_END)
			|| (expVCount(n) >= V_BLANK_START);
	endfunction

	// True on the first sample of a line
	function automatic bit lineStarts(input logic [8:0] line);
		return (expVCount(cycleNo) == line) && (expVCount(cycleNo - 1) != line);
	endfunction

	// Last word written to a VRAM address
	function automatic hostWord_t expectedWord(input int addr);
		hostWord_t result;
		int i;
		result = 'x;
		for (i = 0; i < 8; i++)
			if (wrAddr[i] == addr)
				result = wrWord[i];
		return result;
	endfunction

	task automatic hostWr(input logic [2:0] addr, input hostWord_t data);
		@(posedge CLK_24M);
		#5;
		hostAddr = addr;
		hostWrData = data;
		hostWrite = 1'b1;
		@(posedge CLK_24M);
		#5;
		hostWrite = 1'b0;
		// Idle address keeps the mode readback under watch
		hostAddr = REG_LSPCMODE;
	endtask

	task automatic readReg(input logic [2:0] addr, output hostWord_t data);
		@(posedge CLK_24M);
		#5;
		hostAddr = addr;
		@(negedge CLK_24M);
		data = hostRdData;
	endtask

	// Busy rise, then fall inside one pixel period
	task automatic waitIdle();
		int guard;
		int busyCycles;
		guard = 0;
		while (!vramBusy && guard < 4)
		begin
			@(negedge CLK_24M);
			guard++;
		end
		assert (vramBusy) else abortRun("vramBusy never rose after a VRAM command");
		busyCycles = 0;
		while (vramBusy && busyCycles < 8)
		begin
			@(negedge CLK_24M);
			busyCycles++;
		end
		assert (!vramBusy && busyCycles <= 4)
			else abortRun($sformatf("vramBusy stayed high %0d cycles, limit 4", busyCycles));
	endtask

	task automatic waitLevel(input logic [1:0] level, input int limit);
		int waited;
		waited = 0;
		while (irqLevel != level && waited < limit)
		begin
			@(negedge CLK_24M);
			waited++;
		end
		assert (irqLevel == level)
			else abortRun($sformatf("irqLevel did not reach %0d in %0d cycles", level, limit));
	endtask

	task automatic waitLineStart(input logic [8:0] line, input int limit);
		int waited;
		waited = 0;
		while (!lineStarts(line) && waited < limit)
		begin
			@(negedge CLK_24M);
			waited++;
		end
		assert (lineStarts(line))
			else abortRun($sformatf("raster never reached line %h", line));
	endtask

	// Border lines with timerStop set
	task automatic holdNoTimerIrq(input logic [8:0] endLine, input int limit);
		int waited;
		waited = 0;
		while (!lineStarts(endLine) && waited < limit)
		begin
			@(negedge CLK_24M);
			waited++;
			assert (irqLevel != 2'd2)
				else abortRun($sformatf("timer interrupt on stopped line %h", expVCount(cycleNo)));
		end
		assert (lineStarts(endLine)) else abortRun("border line watch timed out");
	endtask

	// 4M toggles every 3 cycles, 8M high one cycle in 3
	always @(negedge CLK_24M)
	begin
		if (RESET)
		begin
			last4M = 1'b0;
			since4M = 0;
			seen4M = 1'b0;
			since8M = 0;
			seen8M = 1'b0;
		end
		else
		begin
			since4M++;
			since8M++;
			if (clk4M !== last4M)
			begin
				if (seen4M)
					assert (since4M == 3)
						else abortRun($sformatf("clk4M toggled after %0d cycles", since4M));
				seen4M = 1'b1;
				since4M = 0;
				last4M = clk4M;
			end
			if (clk8M)
			begin
				if (seen8M)
					assert (since8M == 3)
						else abortRun($sformatf("clk8M high again after %0d cycles", since8M));
				seen8M = 1'b1;
				since8M = 0;
			end
		end
	end

	// Sync pulse spans 8 lines
	always @(negedge CLK_24M)
	begin
		if (RESET)
			vsyncLowCycles = 0;
		else if (!vsyncN)
			vsyncLowCycles++;
		else if (vsyncLowCycles != 0)
		begin
			assert (vsyncLowCycles == 8 * LINE_CYCLES)
				else abortRun($sformatf("MISMATCH vsyncN low cycles: got %h, expected %h",
					vsyncLowCycles, 8 * LINE_CYCLES));
			vsyncLowCycles = 0;
		end
	end

	// Hsync and blank sampled mid-pixel, clear of the registered output delay
	always @(negedge CLK_24M)
	begin
		if (!RESET && (cycleNo % 4 == 2))
		begin
			assert (hsync == (expHCount(cycleNo) < 29))
				else abortRun($sformatf("MISMATCH hsync: got %h, expected %h",
					hsync, expHCount(cycleNo) < 29));
			assert (blank == expBlank(cycleNo))
				else abortRun($sformatf("MISMATCH blank: got %h, expected %h",
					blank, expBlank(cycleNo)));
		end
	end

	// Mode readback while the bus idles on it
	always @(negedge CLK_24M)
	begin
		if (RESET || hostAddr != REG_LSPCMODE)
			modeSampleValid = 1'b0;
		else
		begin
			modeVCount = hostRdData[15:7];
			assert (hostRdData[6:0] == {3'b000, VIDEO_MODE, 3'b000})
				else abortRun($sformatf("MISMATCH hostRdData[6:0]: got %h, expected %h",
					hostRdData[6:0], {3'b000, VIDEO_MODE, 3'b000}));
			assert (modeVCount >= V_FIRST)
				else abortRun($sformatf("LSPCMODE line %h is outside F8 to 1FF", modeVCount));
			if (modeSampleValid)
				assert (modeVCount == lastModeVCount || modeVCount == lastModeVCount + 9'd1
					|| (lastModeVCount == V_LAST && modeVCount == V_FIRST))
					else abortRun($sformatf("LSPCMODE line jumped from %h to %h",
						lastModeVCount, modeVCount));
			assert (modeVCount == expVCount(cycleNo))
				else abortRun($sformatf("MISMATCH vCount: got %h, expected %h",
					modeVCount, expVCount(cycleNo)));
			lastModeVCount = modeVCount;
			modeSampleValid = 1'b1;
		end
	end

	initial
	begin
		seedValue = 32'hc867_327d;
		void'($urandom(seedValue));
		RESET = 1'b1;
		hostAddr = REG_LSPCMODE;
		hostWrData = '0;
		hostWrite = 1'b0;
		repeat (2) @(posedge CLK_24M);
		#5;
		RESET = 1'b0;

		// Cold boot pending out of reset
		@(negedge CLK_24M);
		assert (irqLevel == 2'd3)
			else abortRun($sformatf("MISMATCH irqLevel: got %h, expected %h", irqLevel, 2'd3));
		assert (vramBusy == 1'b0)
			else abortRun($sformatf("MISMATCH vramBusy: got %h, expected %h", vramBusy, 1'b0));
		hostWr(REG_IRQACK, 16'h0004);
		waitLevel(2'd0, 4);

		// VRAM window with a random step
		vramModWord = 16'($urandom);
		vramBase = $urandom & ADDR_MASK;
		hostWr(REG_VRAMMOD, vramModWord);
		readReg(REG_VRAMMOD, rdWord);
		assert (rdWord == vramModWord)
			else abortRun($sformatf("MISMATCH VRAMMOD: got %h, expected %h", rdWord, vramModWord));
		readReg(REG_TIMERHI, rdWord);
		assert (rdWord == 16'h0000)
			else abortRun($sformatf("MISMATCH TIMERHI read: got %h, expected %h", rdWord, 16'h0));
		hostWr(REG_VRAMADDR, 16'(vramBase));
		waitIdle();
		vramPtr = vramBase;
		for (k = 0; k < 8; k++)
		begin
			dataWord = 16'($urandom);
			hostWr(REG_VRAMDATA, dataWord);
			waitIdle();
			wrAddr[k] = vramPtr;
			wrWord[k] = dataWord;
			vramPtr = (vramPtr + int'(vramModWord)) & ADDR_MASK;
		end
		// Address write fetches the word into the read buffer
		for (k = 0; k < 8; k++)
		begin
			vramPtr = (vramBase + k * int'(vramModWord)) & ADDR_MASK;
			hostWr(REG_VRAMADDR, 16'(vramPtr));
			waitIdle();
			readReg(REG_VRAMADDR, rdWord);
			assert (rdWord === expectedWord(vramPtr))
				else abortRun($sformatf("MISMATCH hostRdData at VRAM %h: got %h, expected %h",
					vramPtr, rdWord, expectedWord(vramPtr)));
		end

		// Mode word, VIDEO_MODE in bit 3
		readReg(REG_LSPCMODE, rdWord);
		assert (rdWord[3] == VIDEO_MODE)
			else abortRun($sformatf("MISMATCH LSPCMODE[3]: got %h, expected %h",
				rdWord[3], VIDEO_MODE));

		// Vertical blank interrupt
		hostWr(REG_IRQACK, 16'h0007);
		waitLevel(2'd0, 4);
		waitLineStart(V_BLANK_START, FRAME_CYCLES + 8);
		assert (irqLevel == 2'd0)
			else abortRun($sformatf("MISMATCH irqLevel: got %h, expected %h", irqLevel, 2'd0));
		@(negedge CLK_24M);
		assert (irqLevel == 2'd1)
			else abortRun($sformatf("MISMATCH irqLevel: got %h, expected %h", irqLevel, 2'd1));
		hostWr(REG_IRQACK, 16'h0001);
		waitLevel(2'd0, 4);

		// Periodic timer, mode field in bits 7 to 5
		timerCnt = 8 + ($urandom % 56);
		periodBound = 4 * (timerCnt + 1) + 8;
		modeBits = 3'b000;
		modeBits[TMODE_ON_WRITE] = 1'b1;
		modeBits[TMODE_ON_ZERO] = 1'b1;
		hostWr(REG_LSPCMODE, {8'h00, modeBits, 1'b0, 4'h0});
		hostWr(REG_TIMERHI, 16'h0000);
		hostWr(REG_TIMERLO, 16'(timerCnt));
		// Active lines keep the timer running
		waitLineStart(9'h120, FRAME_CYCLES + 8);
		hostWr(REG_LSPCMODE, {8'h00, modeBits, 1'b1, 4'h0});
		hostWr(REG_IRQACK, 16'h0002);
		waitLevel(2'd2, periodBound);
		hostWr(REG_IRQACK, 16'h0002);
		waitLevel(2'd0, 4);
		waitLevel(2'd2, periodBound);

		// PAL border stop
		hostWr(REG_TIMERSTOP, 16'h0001);
		waitLineStart(V_BLANK_START, FRAME_CYCLES + 8);
		hostWr(REG_IRQACK, 16'h0003);
		waitLevel(2'd0, 4);
		holdNoTimerIrq(V_BLANK_END, FRAME_CYCLES);
		// Counting resumes past the top border
		waitLevel(2'd2, periodBound);

		$display("Test OK");
		$finish;
	end

endmodule

/* rtl/hostRegisters.sv */
`timescale 1ns/1ps

module hostRegisters #(
	parameter bit VIDEO_MODE = 1'b1
) (
	input  logic              CLK_24M,
	input  logic              RESET,
	input  logic [2:0]        hostAddr,
	input  lspcPkg::hostWord_t hostWrData,
	input  logic              hostWrite,
	output lspcPkg::hostWord_t hostRdData,
	input  logic [8:0]        vCount,
	input  lspcPkg::hostWord_t vramReadData,
	output logic              vramAddrWrite,
	output logic              vramDataWrite,
	output lspcPkg::hostWord_t vramMod,
	output logic [31:0]       timerLoad,
	output logic [2:0]        timerMode,
	output logic              timerIrqEnable,
	output logic              timerStop,
	output logic              timerLoadStrobe,
	output logic [2:0]        irqAck
);

	import lspcPkg::*;

	// Mode readback word
	hostWord_t lspcMode;

	// vCount on top, video mode in bit 3
	// Animation counter field stays zero
	assign lspcMode = {vCount, 3'b000, VIDEO_MODE, 3'b000};

	// Register state, written at the edge that samples hostWrite
	always_ff @(posedge CLK_24M or posedge RESET)
	begin
		if (RESET)
		begin
			vramMod <= '0;
			timerLoad <= '0;
			timerMode <= 3'b000;
			timerIrqEnable <= 1'b0;
			timerStop <= 1'b0;
		end
		else if (hostWrite)
		begin
			case (hostAddr)
				REG_VRAMMOD:
					vramMod <= hostWrData;
				REG_LSPCMODE:
				begin
					// Speed byte and AA disable ignored, no animation here
					timerMode <= hostWrData[7:5];
					timerIrqEnable <= hostWrData[4];
				end
				REG_TIMERHI:
					timerLoad[31:16] <= hostWrData;
				REG_TIMERLO:
					timerLoad[15:0] <= hostWrData;
				REG_TIMERSTOP:
					timerStop <= hostWrData[0];
				default:
					;
			endcase
		end
	end

	// Command pulses, one cycle after the write edge
	always_ff @(posedge CLK_24M or posedge RESET)
	begin
		if (RESET)
		begin
			vramAddrWrite <= 1'b0;
			vramDataWrite <= 1'b0;
			timerLoadStrobe <= 1'b0;
			irqAck <= 3'b000;
		end
		else
		begin
			// Address write also starts a VRAM read
			vramAddrWrite <= hostWrite && (hostAddr == REG_VRAMADDR);
			vramDataWrite <= hostWrite && (hostAddr == REG_VRAMDATA);
			// Low half completes the 32-bit load value
			timerLoadStrobe <= hostWrite && (hostAddr == REG_TIMERLO);
			// One bit per source, 1 clears
			if (hostWrite && (hostAddr == REG_IRQACK))
				irqAck <= hostWrData[2:0];
			else
				irqAck <= 3'b000;
		end
	end

	// Read mux, no strobe
	always_comb
	begin
		case (hostAddr)
			REG_VRAMADDR,
			REG_VRAMDATA:
				hostRdData = vramReadData;
			REG_VRAMMOD:
				hostRdData = vramMod;
			REG_LSPCMODE:
				hostRdData = lspcMode;
			default:
				// Write-only registers
				hostRdData = '0;
		endcase
	end

endmodule

/* rtl/interruptControl.sv */
`timescale 1ns/1ps

module interruptControl (
	input  logic       CLK_24M,
	input  logic       RESET,
	input  logic       vblankStart,
	input  logic       timerIrq,
	input  logic [2:0] irqAck,
	output logic [1:0] irqLevel
);

	import lspcPkg::*;

	logic [2:0] irqPending;
	logic [2:0] irqSource;

	// Cold boot only comes from reset
	always_comb
	begin
		irqSource = 3'b000;
		irqSource[IRQ_VBL] = vblankStart;
		irqSource[IRQ_TIMER] = timerIrq;
	end

	always_ff @(posedge CLK_24M or posedge RESET)
	begin
		if (RESET)
		begin
			irqPending <= 3'b000;
			irqPending[IRQ_COLD] <= 1'b1;
		end
		else
			// New request wins over a same-cycle ack
			irqPending <= (irqPending & ~irqAck) | irqSource;
	end

	// Highest pending source sets the level
	always_comb
	begin
		if (irqPending[IRQ_COLD])
			irqLevel = 2'd3;
		else if (irqPending[IRQ_TIMER])
			irqLevel = 2'd2;
		else if (irqPending[IRQ_VBL])
			irqLevel = 2'd1;
		else
			irqLevel = 2'd0;
	end

endmodule

/* rtl/lspcPkg.sv */
package lspcPkg;

	// One 68000 data word
	typedef logic [15:0] hostWord_t;

	// Register word indices, 3C0000 up to 3C000E
	localparam logic [2:0] REG_VRAMADDR  = 3'd0;
	localparam logic [2:0] REG_VRAMDATA  = 3'd1;
	localparam logic [2:0] REG_VRAMMOD   = 3'd2;
	localparam logic [2:0] REG_LSPCMODE  = 3'd3;
	localparam logic [2:0] REG_TIMERHI   = 3'd4;
	localparam logic [2:0] REG_TIMERLO   = 3'd5;
	localparam logic [2:0] REG_IRQACK    = 3'd6;
	localparam logic [2:0] REG_TIMERSTOP = 3'd7;

	// Pixels per line
	localparam int H_TOTAL = 384;

	// Vertical range, 264 lines per frame
	localparam logic [8:0] V_FIRST = 9'h0F8;
	localparam logic [8:0] V_LAST  = 9'h1FF;

	// Active picture lies between these two lines
	localparam logic [8:0] V_BLANK_END   = 9'h110;
	localparam logic [8:0] V_BLANK_START = 9'h1F0;

	// Bits of the timer mode field
	localparam int TMODE_ON_WRITE  = 0;
	localparam int TMODE_ON_VBLANK = 1;
	localparam int TMODE_ON_ZERO   = 2;

	// Interrupt source vector, also the ack bit order
	localparam int IRQ_VBL   = 0;
	localparam int IRQ_TIMER = 1;
	localparam int IRQ_COLD  = 2;

endpackage

/* rtl/lspcTop.sv */
`timescale 1ns/1ps

module lspcTop #(
	parameter bit VIDEO_MODE = 1'b1,
	parameter int VRAM_AW = 16
) (
	input  logic              CLK_24M,
	input  logic              RESET,
	input  logic [2:0]        hostAddr,
	input  lspcPkg::hostWord_t hostWrData,
	input  logic              hostWrite,
	output lspcPkg::hostWord_t hostRdData,
	output logic              vramBusy,
	output logic [1:0]        irqLevel,
	output logic              hsync,
	output logic              vsyncN,
	output logic              blank,
	output logic              clk8M,
	output logic              clk4M
);

	import lspcPkg::*;

	logic pixelEnable;
	logic [8:0] vCount;
	logic vblankStart;
	// Host side to VRAM window
	logic vramAddrWrite;
	logic vramDataWrite;
	hostWord_t vramMod;
	hostWord_t vramReadData;
	// Host side to timer
	logic [31:0] timerLoad;
	logic [2:0] timerMode;
	logic timerIrqEnable;
	logic timerStop;
	logic timerLoadStrobe;
	logic timerIrq;
	logic [2:0] irqAck;

	pixelClockGen uClk (
		.CLK_24M(CLK_24M), .RESET(RESET), .pixelEnable(pixelEnable),
		.clk8M(clk8M), .clk4M(clk4M)
	);

	hostRegisters #(.VIDEO_MODE(VIDEO_MODE)) uRegs (
		.CLK_24M(CLK_24M), .RESET(RESET),
		.hostAddr(hostAddr), .hostWrData(hostWrData), .hostWrite(hostWrite),
		.hostRdData(hostRdData), .vCount(vCount), .vramReadData(vramReadData),
		.vramAddrWrite(vramAddrWrite), .vramDataWrite(vramDataWrite), .vramMod(vramMod),
		.timerLoad(timerLoad), .timerMode(timerMode), .timerIrqEnable(timerIrqEnable),
		.timerStop(timerStop), .timerLoadStrobe(timerLoadStrobe), .irqAck(irqAck)
	);

	// Horizontal count has no user outside the raster block
	videoCounter uRaster (
		.CLK_24M(CLK_24M), .RESET(RESET), .pixelEnable(pixelEnable),
		.hCount(), .vCount(vCount), .hsync(hsync), .vsyncN(vsyncN),
		.blank(blank), .vblankStart(vblankStart)
	);

	rasterTimer #(.VIDEO_MODE(VIDEO_MODE)) uTimer (
		.CLK_24M(CLK_24M), .RESET(RESET), .pixelEnable(pixelEnable),
		.vCount(vCount), .vblankStart(vblankStart), .timerLoad(timerLoad),
		.timerMode(timerMode), .timerIrqEnable(timerIrqEnable), .timerStop(timerStop),
		.timerLoadStrobe(timerLoadStrobe), .timerIrq(timerIrq)
	);

	vramPort #(.VRAM_AW(VRAM_AW)) uVram (
		.CLK_24M(CLK_24M), .RESET(RESET), .pixelEnable(pixelEnable),
		.vramAddrWrite(vramAddrWrite), .vramDataWrite(vramDataWrite),
		.hostWrData(hostWrData), .vramMod(vramMod),
		.vramReadData(vramReadData), .vramBusy(vramBusy)
	);

	interruptControl uIrq (
		.CLK_24M(CLK_24M), .RESET(RESET), .vblankStart(vblankStart),
		.timerIrq(timerIrq), .irqAck(irqAck), .irqLevel(irqLevel)
	);

endmodule

/* rtl/pixelClockGen.sv */
`timescale 1ns/1ps

module pixelClockGen (
	input  logic CLK_24M,
	input  logic RESET,
	output logic pixelEnable,
	output logic clk8M,
	output logic clk4M
);

	// Divide by 4 for the 6 MHz pixel rate
	logic [1:0] pixCnt;
	// Divide by 3 for the 8 MHz and 4 MHz outputs
	logic [1:0] divCnt;

	// One cycle in four
	assign pixelEnable = (pixCnt == 2'd3);

	always_ff @(posedge CLK_24M or posedge RESET)
	begin
		if (RESET)
		begin
			pixCnt <= 2'd0;
			divCnt <= 2'd0;
			clk8M <= 1'b0;
			clk4M <= 1'b0;
		end
		else
		begin
			pixCnt <= pixCnt + 2'd1;
			// 8M output is a 1-in-3 pulse
			clk8M <= (divCnt == 2'd2);
			if (divCnt == 2'd2)
			begin
				divCnt <= 2'd0;
				// Half the 8M rate
				clk4M <= ~clk4M;
			end
			else
				divCnt <= divCnt + 2'd1;
		end
	end

endmodule

/* rtl/rasterTimer.sv */
`timescale 1ns/1ps

module rasterTimer #(
	parameter bit VIDEO_MODE = 1'b1
) (
	input  logic        CLK_24M,
	input  logic        RESET,
	input  logic        pixelEnable,
	input  logic [8:0]  vCount,
	input  logic        vblankStart,
	input  logic [31:0] timerLoad,
	input  logic [2:0]  timerMode,
	input  logic        timerIrqEnable,
	input  logic        timerStop,
	input  logic        timerLoadStrobe,
	output logic        timerIrq
);

	import lspcPkg::*;

	logic [31:0] timerCount;
	logic borderTop;
	logic borderBot;
	logic timerRun;

	// Lines 100-10F and 1F0-1FF
	assign borderTop = (vCount[7:4] == 4'h0);
	assign borderBot = (vCount[7:4] == 4'hF);

	// Stopped on F8-FF always, on the borders only for PAL with stop set
	assign timerRun = vCount[8] && !(VIDEO_MODE && timerStop && (borderTop || borderBot));

	always_ff @(posedge CLK_24M or posedge RESET)
	begin
		if (RESET)
		begin
			timerCount <= '0;
			timerIrq <= 1'b0;
		end
		else
		begin
			timerIrq <= 1'b0;
			// Immediate reloads take priority over counting
			if (timerLoadStrobe && timerMode[TMODE_ON_WRITE])
				timerCount <= timerLoad;
			else if (vblankStart && timerMode[TMODE_ON_VBLANK])
				timerCount <= timerLoad;
			else if (pixelEnable && timerRun)
			begin
				if (timerCount != 32'd0)
					timerCount <= timerCount - 32'd1;
				else
				begin
					// Expired
					timerIrq <= timerIrqEnable;
					if (timerMode[TMODE_ON_ZERO])
						timerCount <= timerLoad;
				end
			end
		end
	end

endmodule

/* rtl/videoCounter.sv */
`timescale 1ns/1ps

module videoCounter (
	input  logic       CLK_24M,
	input  logic       RESET,
	input  logic       pixelEnable,
	output logic [8:0] hCount,
	output logic [8:0] vCount,
	output logic       hsync,
	output logic       vsyncN,
	output logic       blank,
	output logic       vblankStart
);

	import lspcPkg::*;

	// Last pixel of the line
	logic lineEnd;

	assign lineEnd = (hCount == 9'(H_TOTAL - 1));

	// Raster position
	always_ff @(posedge CLK_24M or posedge RESET)
	begin
		if (RESET)
		begin
			hCount <= 9'd0;
			vCount <= V_FIRST;
			vblankStart <= 1'b0;
		end
		else
		begin
			// Pulse lines up with vCount reaching V_BLANK_START
			vblankStart <= pixelEnable && lineEnd && (vCount == V_BLANK_START - 9'd1);
			if (pixelEnable)
			begin
				if (lineEnd)
				begin
					hCount <= 9'd0;
					// Frame wraps back to F8
					if (vCount == V_LAST)
						vCount <= V_FIRST;
					else
						vCount <= vCount + 9'd1;
				end
				else
					hCount <= hCount + 9'd1;
			end
		end
	end

	// Sync and blank, registered one cycle behind the counters
	always_ff @(posedge CLK_24M or posedge RESET)
	begin
		if (RESET)
		begin
			hsync <= 1'b0;
			vsyncN <= 1'b1;
			blank <= 1'b0;
		end
		else
		begin
			hsync <= (hCount < 9'd29);
			// First 8 lines of the frame
			vsyncN <= !((vCount >= V_FIRST) && (vCount <= V_FIRST + 9'd7));
			// Vertical borders or right side of the line
			blank <= (vCount < V_BLANK_END) || (vCount >= V_BLANK_START) || (hCount >= 9'd320);
		end
	end

endmodule

/* rtl/vramPort.sv */
`timescale 1ns/1ps

module vramPort #(
	parameter int VRAM_AW = 16
) (
	input  logic              CLK_24M,
	input  logic              RESET,
	input  logic              pixelEnable,
	input  logic              vramAddrWrite,
	input  logic              vramDataWrite,
	input  lspcPkg::hostWord_t hostWrData,
	input  lspcPkg::hostWord_t vramMod,
	output lspcPkg::hostWord_t vramReadData,
	output logic              vramBusy
);

	import lspcPkg::*;

	logic [VRAM_AW-1:0] vramAddr;
	// Write data waiting for the CPU slot
	hostWord_t writeBuf;
	// Bus data delayed to line up with the command pulses
	hostWord_t busDataQ;
	// Kind of the pending access, 1 = write
	logic pendWrite;
	logic cmdAccept;
	logic slotAccess;

	hostWord_t vram [2**VRAM_AW];

	// Commands while busy are dropped
	assign cmdAccept = (vramAddrWrite || vramDataWrite) && !vramBusy;

	// CPU slot is the pixel enable, other three belong to video fetch
	assign slotAccess = vramBusy && pixelEnable;

	always_ff @(posedge CLK_24M)
	begin
		busDataQ <= hostWrData;
	end

	// Address and pending state
	always_ff @(posedge CLK_24M or posedge RESET)
	begin
		if (RESET)
		begin
			vramAddr <= '0;
			pendWrite <= 1'b0;
			vramBusy <= 1'b0;
		end
		else if (cmdAccept)
		begin
			vramBusy <= 1'b1;
			pendWrite <= vramDataWrite;
			if (vramAddrWrite)
				vramAddr <= VRAM_AW'(busDataQ);
		end
		else if (slotAccess)
		begin
			vramBusy <= 1'b0;
			// Step by the modulo once the word is stored
			if (pendWrite)
				vramAddr <= vramAddr + VRAM_AW'(vramMod);
		end
	end

	// Memory, write buffer and read buffer
	always_ff @(posedge CLK_24M)
	begin
		if (cmdAccept && vramDataWrite)
			writeBuf <= busDataQ;
		if (slotAccess)
		begin
			if (pendWrite)
				vram[vramAddr] <= writeBuf;
			else
				// Read buffer valid as busy falls
				vramReadData <= vram[vramAddr];
		end
	end

endmodule
